/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := main_mem_tb
FLIST     := main_mem.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/main_mem_chk.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

module main_mem_chk
  import main_mem_cmd_pkg::*;
(
  input logic                  clk,
  input logic                  i_rst_n,
  input mem_cmd_e              i_r_cmd,
  input mem_cmd_e              i_w_cmd,
  input logic [`MM_IDX_W-1:0]  i_r_index,
  input logic [`MM_IDX_W-1:0]  i_w_index,
  input logic [`MM_IDX_W-1:0]  o_r_index_next,
  input logic [`MM_IDX_W-1:0]  o_w_index_next,
  input logic                  o_r_has_next,
  input logic                  o_w_has_next,
  input logic [`MM_WORD_W-1:0] o_r_bus
);

  function automatic bit is_cell(input mem_cmd_e c);
    return (c >= cmd_ss && c <= cmd_u);
  endfunction

  ////////////////////
  // idle ports
  a_r_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_r_cmd == cmd_none |-> !o_r_has_next)
    else $error("read has_next high while read port idle");

  a_w_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_w_cmd == cmd_none |-> !o_w_has_next)
    else $error("write has_next high while write port idle");

  a_idle_data: assert property (@(posedge clk) disable iff (!i_rst_n)
    i_r_cmd == cmd_none |-> ##2 (o_r_bus == '0))
    else $error("read bus not zero two cycles after idle read");

  ////////////////////
  // cell regions step by one
  a_r_step: assert property (@(posedge clk) disable iff (!i_rst_n)
    is_cell(i_r_cmd) |-> (o_r_index_next == i_r_index + 14'd1))
    else $error("read next index is not index plus one");

  a_w_step: assert property (@(posedge clk) disable iff (!i_rst_n)
    is_cell(i_w_cmd) |-> (o_w_index_next == i_w_index + 14'd1))
    else $error("write next index is not index plus one");

endmodule

bind main_mem main_mem_chk u_chk (
  .clk            (clk),
  .i_rst_n        (i_rst_n),
  .i_r_cmd        (i_r_cmd),
  .i_w_cmd        (i_w_cmd),
  .i_r_index      (i_r_index),
  .i_w_index      (i_w_index),
  .o_r_index_next (o_r_index_next),
  .o_w_index_next (o_w_index_next),
  .o_r_has_next   (o_r_has_next),
  .o_w_has_next   (o_w_has_next),
  .o_r_bus        (o_r_bus)
);

`default_nettype wire

/* bench/main_mem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

module main_mem_tb
  import main_mem_cmd_pkg::*;
();

  localparam int CYC_RESET = 10;
  localparam int CYC_CELLS = 230;   // one write and two read passes
  localparam int CYC_BROW  = 75;
  localparam int CYC_BMAT  = 25;
  localparam int CYC_BCOL  = 80;
  localparam int CYC_LIMIT = CYC_RESET + CYC_CELLS + CYC_BROW + CYC_BMAT + CYC_BCOL + 100;

  logic                   clk;
  logic                   i_rst_n;
  mem_cmd_e               i_r_cmd;
  logic [`MM_IDX_W-1:0]   i_r_index;
  logic [`MM_IDX_W-1:0]   o_r_index_next;
  logic                   o_r_has_next;
  logic [`MM_WORD_W-1:0]  o_r_bus;
  logic [`MM_PARAL_W-1:0] o_r_paral;
  mem_cmd_e               i_w_cmd;
  logic [`MM_IDX_W-1:0]   i_w_index;
  logic [`MM_WORD_W-1:0]  i_w_bus;
  logic [`MM_PARAL_W-1:0] i_w_paral;
  logic [`MM_IDX_W-1:0]   o_w_index_next;
  logic                   o_w_has_next;
  logic [`MM_NBLK_W-1:0]  i_num_blocks;
  logic [`MM_LEN_W-1:0]   i_len_sec;
  logic [`MM_LEN_W-1:0]   i_len_se;
  logic [`MM_LEN_W-1:0]   i_len_salt;

  int          errors;
  bit          checking;
  string       cur_test;
  logic [63:0] img [512][8];   // reference image, row by column

  // read expectations, [0] issued this cycle, [2] due now
  logic [511:0] pipe_bus   [3];
  logic [511:0] pipe_paral [3];
  bit           pipe_chkp  [3];
  string        pipe_name  [3];

  main_mem u_dut (
    .clk            (clk),
    .i_rst_n        (i_rst_n),
    .i_r_cmd        (i_r_cmd),
    .i_r_index      (i_r_index),
    .o_r_index_next (o_r_index_next),
    .o_r_has_next   (o_r_has_next),
    .o_r_bus        (o_r_bus),
    .o_r_paral      (o_r_paral),
    .i_w_cmd        (i_w_cmd),
    .i_w_index      (i_w_index),
    .i_w_bus        (i_w_bus),
    .i_w_paral      (i_w_paral),
    .o_w_index_next (o_w_index_next),
    .o_w_has_next   (o_w_has_next),
    .i_num_blocks   (i_num_blocks),
    .i_len_sec      (i_len_sec),
    .i_len_se       (i_len_se),
    .i_len_salt     (i_len_salt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_eq(input string what, input logic [511:0] exp, input logic [511:0] act);
    if (act !== exp) begin
      errors++;
      $display("ERR %s: expected %0h, actual %0h", what, exp, act);
    end
  endtask

  ////////////////////
  // reference rules
  function automatic logic [8:0] region_off(input mem_cmd_e c);
    case (c)
      cmd_ss:     return `MM_OFF_SS;
      cmd_rng:    return `MM_OFF_RNG;
      cmd_salt:   return `MM_OFF_SALT;
      cmd_seedse: return `MM_OFF_SEEDSE;
      cmd_pkh:    return `MM_OFF_PKH;
      cmd_k:      return `MM_OFF_K;
      cmd_u:      return `MM_OFF_U;
      default:    return `MM_OFF_B;
    endcase
  endfunction

  function automatic logic [13:0] pick_len(input logic [2:0] oh, input int a, input int b,
                                           input int c);
    if (oh[0]) begin
      return 14'(a);
    end else if (oh[1]) begin
      return 14'(b);
    end
    return 14'(c);
  endfunction

  function automatic logic [13:0] last_index(input mem_cmd_e c);
    logic [8:0] cells;
    cells = 9'(2 * i_num_blocks - 1);
    case (c)
      cmd_b_row:  return {5'd7, cells};
      cmd_b_col:  return 14'(16 * i_num_blocks - 1);
      cmd_b_mat:  return {5'd0, cells};
      cmd_ss:     return `MM_SS_LAST;
      cmd_rng:    return `MM_RNG_LAST;
      cmd_salt:   return pick_len(i_len_salt, 3, 5, 7);
      cmd_seedse: return pick_len(i_len_se, 3, 5, 7);
      default:    return pick_len(i_len_sec, 1, 2, 3);
    endcase
  endfunction

  function automatic logic [13:0] next_index(input mem_cmd_e c, input logic [13:0] idx);
    if (c == cmd_b_row && idx[8:0] == 9'(2 * i_num_blocks - 1)) begin
      return {idx[13:9] + 5'd1, 9'd0};   // on to the next column
    end
    return idx + 14'd1;
  endfunction

  task automatic model_write(input mem_cmd_e c, input logic [13:0] idx, input logic [63:0] bus,
                             input logic [511:0] paral);
    logic [8:0] row;
    int         base;
    row  = region_off(c) + idx[11:3];
    base = idx[0] ? 4 : 0;
    case (c)
      cmd_none: ;
      cmd_b_row: img[`MM_OFF_B + idx[8:0]][idx[11:9]] = bus;
      cmd_b_mat: begin
        for (int k = 0; k < 8; k++) begin
          img[`MM_OFF_B + idx[8:0]][k] = paral[k*64 +: 64];
        end
      end
      cmd_b_col: begin
        for (int k = 0; k < 4; k++) begin
          img[row][base + k][idx[2:1]*16 +: 16] = bus[k*16 +: 16];  // element k, one lane
        end
      end
      default:   img[row][idx[2:0]] = bus;
    endcase
  endtask

  function automatic logic [63:0] model_bus(input mem_cmd_e c, input logic [13:0] idx);
    logic [8:0]  row;
    logic [63:0] v;
    int          base;
    row  = region_off(c) + idx[11:3];
    base = idx[0] ? 4 : 0;
    v    = '0;
    case (c)
      cmd_none:  v = '0;
      cmd_b_row: v = img[`MM_OFF_B + idx[8:0]][idx[11:9]];
      cmd_b_mat: begin
        for (int k = 0; k < 8; k++) begin
          v = v | img[`MM_OFF_B + idx[8:0]][k];
        end
      end
      cmd_b_col: begin
        for (int k = 0; k < 4; k++) begin
          v[k*16 +: 16] = img[row][base + k][idx[2:1]*16 +: 16];
        end
      end
      default:   v = img[row][idx[2:0]];
    endcase
    return v;
  endfunction

  function automatic logic [511:0] model_paral(input mem_cmd_e c, input logic [13:0] idx);
    logic [511:0] v;
    v = '0;
    if (c == cmd_b_mat) begin
      for (int k = 0; k < 8; k++) begin
        v[k*64 +: 64] = img[`MM_OFF_B + idx[8:0]][k];
      end
    end
    return v;
  endfunction

  function automatic logic [511:0] rand_paral();
    logic [511:0] v;
    for (int k = 0; k < 16; k++) begin
      v[k*32 +: 32] = $urandom;
    end
    return v;
  endfunction

  ////////////////////
  // drivers
  task automatic set_read(input mem_cmd_e c, input logic [13:0] idx);
    i_r_cmd       = c;
    i_r_index     = idx;
    pipe_bus[0]   = 512'(model_bus(c, idx));
    pipe_paral[0] = model_paral(c, idx);
    pipe_chkp[0]  = (c == cmd_b_mat || c == cmd_none);
    pipe_name[0]  = $sformatf("%s %s@%0d", cur_test, c.name(), idx);
  endtask

  task automatic set_write(input mem_cmd_e c, input logic [13:0] idx, input logic [63:0] bus,
                           input logic [511:0] paral);
    i_w_cmd   = c;
    i_w_index = idx;
    i_w_bus   = bus;
    i_w_paral = paral;
    model_write(c, idx, bus, paral);
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
    for (int s = 2; s > 0; s--) begin
      pipe_bus[s]   = pipe_bus[s-1];
      pipe_paral[s] = pipe_paral[s-1];
      pipe_chkp[s]  = pipe_chkp[s-1];
      pipe_name[s]  = pipe_name[s-1];
    end
    if (checking) begin
      check_eq({pipe_name[2], " bus"}, pipe_bus[2], 512'(o_r_bus));
      if (pipe_chkp[2]) begin
        check_eq({pipe_name[2], " paral"}, pipe_paral[2], o_r_paral);
      end
    end
    i_w_cmd = cmd_none;
    set_read(cmd_none, '0);
  endtask

  // steps one port through a region by its own next-index output
  task automatic walk(input bit wr, input mem_cmd_e c);
    logic [13:0] idx;
    logic [13:0] nxt;
    logic        more;
    bit          fin;
    string       tag;
    idx = '0;
    fin = 1'b0;
    while (!fin) begin
      tag = $sformatf("%s %s@%0d", cur_test, c.name(), idx);
      if (wr) begin
        set_write(c, idx, {$urandom, $urandom}, rand_paral());
      end else begin
        set_read(c, idx);
      end
      #1;
      nxt  = wr ? o_w_index_next : o_r_index_next;
      more = wr ? o_w_has_next : o_r_has_next;
      check_eq({tag, " next"}, 512'(next_index(c, idx)), 512'(nxt));
      check_eq({tag, " has_next"}, 512'(idx != last_index(c)), 512'(more));
      fin = (idx == last_index(c));
      idx = nxt;
      next_cycle();
    end
  endtask

  ////////////////////
  // tests
  task automatic test_reset();
    cur_test = "reset";
    repeat (4) begin
      next_cycle();
      check_eq("reset bus", '0, 512'(o_r_bus));
      check_eq("reset paral", '0, o_r_paral);
    end
  endtask

  task automatic test_cells();
    mem_cmd_e regs [7] = '{cmd_salt, cmd_seedse, cmd_pkh, cmd_k, cmd_u, cmd_rng, cmd_ss};
    cur_test   = "cells";
    i_len_sec  = 3'b100;   // longest regions first
    i_len_se   = 3'b100;
    i_len_salt = 3'b100;
    foreach (regs[i]) walk(1'b1, regs[i]);
    foreach (regs[i]) walk(1'b0, regs[i]);
    i_len_sec  = 3'b001;
    i_len_se   = 3'b001;
    i_len_salt = 3'b001;
    foreach (regs[i]) walk(1'b0, regs[i]);
  endtask

  task automatic test_b_row();
    cur_test     = "b_row";
    i_num_blocks = 8'd2;
    walk(1'b1, cmd_b_row);
    walk(1'b0, cmd_b_row);
  endtask

  task automatic test_b_mat();
    cur_test = "b_mat";
    walk(1'b1, cmd_b_mat);
    walk(1'b0, cmd_b_mat);
    for (int r = 0; r < 4; r++) begin
      set_read(cmd_b_row, {2'b00, 3'($urandom), 9'(r)});  // one column word
      next_cycle();
    end
  endtask

  task automatic test_b_col();
    cur_test = "b_col";
    walk(1'b1, cmd_b_col);
    walk(1'b0, cmd_b_col);
    set_read(cmd_b_mat, 14'd1);
    next_cycle();
  endtask

  initial begin
    void'($urandom(52));
    errors       = 0;
    checking     = 1'b0;
    cur_test     = "init";
    i_rst_n      = 1'b0;
    i_w_cmd      = cmd_none;
    i_w_index    = '0;
    i_w_bus      = '0;
    i_w_paral    = '0;
    i_num_blocks = 8'd2;
    i_len_sec    = 3'b100;
    i_len_se     = 3'b100;
    i_len_salt   = 3'b100;
    for (int s = 0; s < 3; s++) begin
      set_read(cmd_none, '0);
      pipe_bus[s]   = '0;
      pipe_paral[s] = '0;
      pipe_chkp[s]  = 1'b1;
      pipe_name[s]  = "idle";
    end
    repeat (2) @(posedge clk);
    #1;
    i_rst_n  = 1'b1;
    checking = 1'b1;
    test_reset();
    test_cells();
    test_b_row();
    test_b_mat();
    test_b_col();
    repeat (3) next_cycle();   // drain reads in flight
    $display("tests done, %0d errors", errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    repeat (CYC_LIMIT) @(posedge clk);
    $display("timeout, tests did not finish within %0d cycles", CYC_LIMIT);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

/* include/main_mem_defs.svh */
`ifndef MAIN_MEM_DEFS_SVH
`define MAIN_MEM_DEFS_SVH

////////////////////
// bank geometry
`define MM_COLS     8     // block-ram columns
`define MM_ROWS     512
`define MM_ROW_W    9
`define MM_WORD_W   64    // one column word
`define MM_PARAL_W  512   // all columns side by side

////////////////////
// logical access
`define MM_IDX_W    14
`define MM_ELEM_W   16    // B element
`define MM_NBLK_W   8     // num_blocks field
`define MM_LEN_W    3     // one-hot length fields

////////////////////
// region row offsets
`define MM_OFF_SS      9'd0
`define MM_OFF_C       (`MM_OFF_SS + 9'd4)      // C is gone, rows kept
`define MM_OFF_RNG     (`MM_OFF_C + 9'd2)
`define MM_OFF_SALT    (`MM_OFF_RNG + 9'd1)
`define MM_OFF_SEEDSE  (`MM_OFF_SALT + 9'd1)
`define MM_OFF_PKH     (`MM_OFF_SEEDSE + 9'd1)
`define MM_OFF_U       (`MM_OFF_PKH + 9'd1)
`define MM_OFF_K       (`MM_OFF_U + 9'd1)
`define MM_OFF_B       (`MM_OFF_K + 9'd1)

// last index of the fixed-length regions
`define MM_SS_LAST     14'd24
`define MM_RNG_LAST    14'd7

`endif

/* main_mem.f */
+incdir+include
verilog/main_mem_cmd_pkg.sv
verilog/main_mem_cfg_pkg.sv
verilog/mem_bank_if.sv
verilog/bram_column.sv
verilog/bram_bank.sv
verilog/access_map.sv
verilog/main_mem_read_port.sv
verilog/main_mem_write_port.sv
verilog/main_mem.sv
bench/main_mem_chk.sv
bench/main_mem_tb.sv

/* verilog/access_map.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

module access_map
  import main_mem_cmd_pkg::*, main_mem_cfg_pkg::*;
(
  input  mem_cmd_e              i_cmd,
  input  logic [`MM_IDX_W-1:0]  i_index,
  input  mem_cfg_t              i_cfg,
  output logic [`MM_ROW_W-1:0]  o_row,
  output logic [`MM_COLS*8-1:0] o_en,
  output logic [`MM_IDX_W-1:0]  o_index_next,
  output logic                  o_has_next
);

  mem_limits_t          lim;
  logic [`MM_ROW_W-1:0] offset;
  logic [`MM_ROW_W-1:0] local_row;
  logic [`MM_COLS-1:0]  col_en;
  logic [7:0]           byte_en;
  logic                 row_wrap;

  always_comb begin
    lim.cells_min1    = {i_cfg.num_blocks, 1'b0} - 9'd1;
    lim.cells_x8_min1 = {2'b00, i_cfg.num_blocks, 4'b0000} - 14'd1;
    lim.sec_min1      = i_cfg.len_sec[0]  ? 14'd1 : i_cfg.len_sec[1]  ? 14'd2 : 14'd3;
    lim.se_min1       = i_cfg.len_se[0]   ? 14'd3 : i_cfg.len_se[1]   ? 14'd5 : 14'd7;
    lim.salt_min1     = i_cfg.len_salt[0] ? 14'd3 : i_cfg.len_salt[1] ? 14'd5 : 14'd7;
  end

  ////////////////////
  // row and enables
  always_comb begin
    local_row = i_index[11:3];            // cells and b_col: 8 per row
    col_en    = 8'h01 << i_index[2:0];
    byte_en   = 8'hff;
    case (i_cmd)
      cmd_ss:     offset = `MM_OFF_SS;
      cmd_rng:    offset = `MM_OFF_RNG;
      cmd_salt:   offset = `MM_OFF_SALT;
      cmd_seedse: offset = `MM_OFF_SEEDSE;
      cmd_pkh:    offset = `MM_OFF_PKH;
      cmd_k:      offset = `MM_OFF_K;
      cmd_u:      offset = `MM_OFF_U;
      cmd_b_row: begin
        offset    = `MM_OFF_B;
        local_row = i_index[`MM_ROW_W-1:0];
        col_en    = 8'h01 << i_index[11:9];
      end
      cmd_b_col: begin
        offset  = `MM_OFF_B;
        col_en  = i_index[0] ? 8'hf0 : 8'h0f;
        byte_en = 8'h03 << {i_index[2:1], 1'b0};  // one 16-bit lane
      end
      cmd_b_mat: begin
        offset    = `MM_OFF_B;
        local_row = i_index[`MM_ROW_W-1:0];
        col_en    = 8'hff;
      end
      default: begin
        offset  = '0;
        col_en  = '0;
        byte_en = '0;
      end
    endcase
  end

  assign o_row = offset + local_row;

  always_comb begin
    for (int c = 0; c < `MM_COLS; c++) begin
      for (int b = 0; b < 8; b++) begin
        o_en[c*8 + b] = col_en[c] & byte_en[b];
      end
    end
  end

  ////////////////////
  // stepping
  always_comb begin
    row_wrap     = (i_index[`MM_ROW_W-1:0] == lim.cells_min1);
    o_index_next = i_index + 14'd1;
    if (i_cmd == cmd_b_row && row_wrap) begin
      o_index_next = {i_index[13:9] + 5'd1, 9'd0};  // next column
    end
    case (i_cmd)
      cmd_b_row:      o_has_next = (i_index != {5'd7, lim.cells_min1});
      cmd_b_col:      o_has_next = (i_index != lim.cells_x8_min1);
      cmd_b_mat:      o_has_next = (i_index != {5'd0, lim.cells_min1});
      cmd_ss:         o_has_next = (i_index != `MM_SS_LAST);
      cmd_rng:        o_has_next = (i_index != `MM_RNG_LAST);
      cmd_salt:       o_has_next = (i_index != lim.salt_min1);
      cmd_seedse:     o_has_next = (i_index != lim.se_min1);
      cmd_pkh, cmd_k,
      cmd_u:          o_has_next = (i_index != lim.sec_min1);
      default:        o_has_next = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/bram_bank.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

module bram_bank (
  input logic       clk,
  input logic       i_rst_n,
  mem_bank_if.bank  bank
);

  logic [`MM_COLS*8-1:0]  r_en_d1;
  logic [`MM_COLS*8-1:0]  r_en_d2;   // lines up with column data
  logic [`MM_PARAL_W-1:0] raw_data;

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      r_en_d1 <= '0;
      r_en_d2 <= '0;
    end else begin
      r_en_d1 <= bank.r_en;
      r_en_d2 <= r_en_d1;
    end
  end

  ////////////////////
  // columns
  for (genvar c = 0; c < `MM_COLS; c++) begin : g_col
    bram_column u_col (
      .clk          (clk),
      .i_rd_en      (|bank.r_en[c*8 +: 8]),
      .i_rd_row     (bank.r_row),
      .o_rd_data    (raw_data[c*`MM_WORD_W +: `MM_WORD_W]),
      .i_wr_byte_en (bank.w_en[c*8 +: 8]),
      .i_wr_row     (bank.w_row),
      .i_wr_data    (bank.w_data[c*`MM_WORD_W +: `MM_WORD_W])
    );

    // unselected bytes read as zero
    for (genvar b = 0; b < 8; b++) begin : g_byte
      assign bank.r_data[c*`MM_WORD_W + b*8 +: 8] =
        raw_data[c*`MM_WORD_W + b*8 +: 8] & {8{r_en_d2[c*8 + b]}};
    end
  end

endmodule

`default_nettype wire

/* verilog/bram_column.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

module bram_column (
  input  logic                  clk,
  input  logic                  i_rd_en,
  input  logic [`MM_ROW_W-1:0]  i_rd_row,
  output logic [`MM_WORD_W-1:0] o_rd_data,
  input  logic [7:0]            i_wr_byte_en,
  input  logic [`MM_ROW_W-1:0]  i_wr_row,
  input  logic [`MM_WORD_W-1:0] i_wr_data
);

  logic [`MM_WORD_W-1:0] mem [`MM_ROWS];
  logic [`MM_WORD_W-1:0] rd_q1;   // read register
  logic [`MM_WORD_W-1:0] rd_q2;   // output register

  always_ff @(posedge clk) begin
    for (int b = 0; b < 8; b++) begin
      if (i_wr_byte_en[b]) begin
        mem[i_wr_row][b*8 +: 8] <= i_wr_data[b*8 +: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_rd_en) begin
      rd_q1 <= mem[i_rd_row];
    end
    rd_q2 <= rd_q1;
  end

  assign o_rd_data = rd_q2;

endmodule

`default_nettype wire

/* verilog/main_mem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

module main_mem
  import main_mem_cmd_pkg::*, main_mem_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_rst_n,
  // read
  input  mem_cmd_e               i_r_cmd,
  input  logic [`MM_IDX_W-1:0]   i_r_index,
  output logic [`MM_IDX_W-1:0]   o_r_index_next,
  output logic                   o_r_has_next,
  output logic [`MM_WORD_W-1:0]  o_r_bus,     // 2 cycles after the command
  output logic [`MM_PARAL_W-1:0] o_r_paral,
  // write
  input  mem_cmd_e               i_w_cmd,
  input  logic [`MM_IDX_W-1:0]   i_w_index,
  input  logic [`MM_WORD_W-1:0]  i_w_bus,
  input  logic [`MM_PARAL_W-1:0] i_w_paral,
  output logic [`MM_IDX_W-1:0]   o_w_index_next,
  output logic                   o_w_has_next,
  // configuration
  input  logic [`MM_NBLK_W-1:0]  i_num_blocks,
  input  logic [`MM_LEN_W-1:0]   i_len_sec,
  input  logic [`MM_LEN_W-1:0]   i_len_se,
  input  logic [`MM_LEN_W-1:0]   i_len_salt
);

  mem_cfg_t cfg;

  assign cfg.num_blocks = i_num_blocks;
  assign cfg.len_sec    = i_len_sec;
  assign cfg.len_se     = i_len_se;
  assign cfg.len_salt   = i_len_salt;

  mem_bank_if bank_if ();

  bram_bank u_bank (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .bank    (bank_if.bank)
  );

  main_mem_read_port u_rd (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_cmd        (i_r_cmd),
    .i_index      (i_r_index),
    .i_cfg        (cfg),
    .o_index_next (o_r_index_next),
    .o_has_next   (o_r_has_next),
    .o_bus        (o_r_bus),
    .o_paral      (o_r_paral),
    .bank         (bank_if.reader)
  );

  main_mem_write_port u_wr (
    .i_cmd        (i_w_cmd),
    .i_index      (i_w_index),
    .i_cfg        (cfg),
    .i_bus        (i_w_bus),
    .i_paral      (i_w_paral),
    .o_index_next (o_w_index_next),
    .o_has_next   (o_w_has_next),
    .bank         (bank_if.writer)
  );

endmodule

`default_nettype wire

/* verilog/main_mem_cfg_pkg.sv */
`default_nettype none

`include "main_mem_defs.svh"

package main_mem_cfg_pkg;

  // runtime parameter set
  typedef struct packed {
    logic [`MM_NBLK_W-1:0] num_blocks;  // 8x8 blocks in B
    logic [`MM_LEN_W-1:0]  len_sec;     // one-hot
    logic [`MM_LEN_W-1:0]  len_se;      // one-hot
    logic [`MM_LEN_W-1:0]  len_salt;    // one-hot
  } mem_cfg_t;

  ////////////////////
  // last indexes derived from mem_cfg_t
  typedef struct packed {
    logic [`MM_ROW_W-1:0] cells_min1;     // 2*num_blocks-1
    logic [`MM_IDX_W-1:0] cells_x8_min1;  // 16*num_blocks-1
    logic [`MM_IDX_W-1:0] sec_min1;
    logic [`MM_IDX_W-1:0] se_min1;
    logic [`MM_IDX_W-1:0] salt_min1;
  } mem_limits_t;

endpackage

`default_nettype wire

/* verilog/main_mem_cmd_pkg.sv */
`default_nettype none

package main_mem_cmd_pkg;

  // one access mode per cycle and port, cmd_none when idle
  typedef enum logic [3:0] {
    cmd_none   = 4'd0,
    // B matrix, 16-bit elements
    cmd_b_row  = 4'd1,   // row first, 1x4
    cmd_b_col  = 4'd2,   // column first, 4x1
    // 64-bit cell regions
    cmd_ss     = 4'd3,
    cmd_rng    = 4'd4,
    cmd_salt   = 4'd5,
    cmd_seedse = 4'd6,
    cmd_pkh    = 4'd7,
    cmd_k      = 4'd8,
    cmd_u      = 4'd9,
    // whole 8x4 block on the parallel bus
    cmd_b_mat  = 4'd10
  } mem_cmd_e;

endpackage

`default_nettype wire

/* verilog/main_mem_read_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

module main_mem_read_port
  import main_mem_cmd_pkg::*, main_mem_cfg_pkg::*;
(
  input  logic                   clk,
  input  logic                   i_rst_n,
  input  mem_cmd_e               i_cmd,
  input  logic [`MM_IDX_W-1:0]   i_index,
  input  mem_cfg_t               i_cfg,
  output logic [`MM_IDX_W-1:0]   o_index_next,
  output logic                   o_has_next,
  output logic [`MM_WORD_W-1:0]  o_bus,
  output logic [`MM_PARAL_W-1:0] o_paral,
  mem_bank_if.reader             bank
);

  mem_cmd_e              cmd_d1;
  mem_cmd_e              cmd_d2;   // aligned with bank.r_data
  logic [`MM_ELEM_W-1:0] lane_or [`MM_COLS];
  logic [`MM_WORD_W-1:0] word_or;

  access_map u_map (
    .i_cmd        (i_cmd),
    .i_index      (i_index),
    .i_cfg        (i_cfg),
    .o_row        (bank.r_row),
    .o_en         (bank.r_en),
    .o_index_next (o_index_next),
    .o_has_next   (o_has_next)
  );

  always_ff @(posedge clk) begin
    if (!i_rst_n) begin
      cmd_d1 <= cmd_none;
      cmd_d2 <= cmd_none;
    end else begin
      cmd_d1 <= i_cmd;
      cmd_d2 <= cmd_d1;
    end
  end

  ////////////////////
  // merge, relies on zeroed unselected bytes
  always_comb begin
    word_or = '0;
    for (int c = 0; c < `MM_COLS; c++) begin
      word_or    = word_or | bank.r_data[c*`MM_WORD_W +: `MM_WORD_W];
      lane_or[c] = bank.r_data[c*`MM_WORD_W      +: `MM_ELEM_W]
                 | bank.r_data[c*`MM_WORD_W + 16 +: `MM_ELEM_W]
                 | bank.r_data[c*`MM_WORD_W + 32 +: `MM_ELEM_W]
                 | bank.r_data[c*`MM_WORD_W + 48 +: `MM_ELEM_W];
    end
  end

  always_comb begin
    o_bus = word_or;
    if (cmd_d2 == cmd_b_col) begin
      for (int k = 0; k < 4; k++) begin
        o_bus[k*`MM_ELEM_W +: `MM_ELEM_W] = lane_or[k] | lane_or[k+4];  // one half is zero
      end
    end
  end

  assign o_paral = bank.r_data;

endmodule

`default_nettype wire

/* verilog/main_mem_write_port.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

module main_mem_write_port
  import main_mem_cmd_pkg::*, main_mem_cfg_pkg::*;
(
  input  mem_cmd_e               i_cmd,
  input  logic [`MM_IDX_W-1:0]   i_index,
  input  mem_cfg_t               i_cfg,
  input  logic [`MM_WORD_W-1:0]  i_bus,
  input  logic [`MM_PARAL_W-1:0] i_paral,
  output logic [`MM_IDX_W-1:0]   o_index_next,
  output logic                   o_has_next,
  mem_bank_if.writer             bank
);

  logic [`MM_PARAL_W-1:0] w_data;

  access_map u_map (
    .i_cmd        (i_cmd),
    .i_index      (i_index),
    .i_cfg        (i_cfg),
    .o_row        (bank.w_row),
    .o_en         (bank.w_en),
    .o_index_next (o_index_next),
    .o_has_next   (o_has_next)
  );

  // spread data wide, the enables pick the bytes
  always_comb begin
    case (i_cmd)
      cmd_b_mat: w_data = i_paral;
      cmd_b_col: begin
        w_data = '0;
        for (int k = 0; k < 4; k++) begin
          w_data[k*`MM_WORD_W +: `MM_WORD_W]     = {4{i_bus[k*`MM_ELEM_W +: `MM_ELEM_W]}};
          w_data[(k+4)*`MM_WORD_W +: `MM_WORD_W] = {4{i_bus[k*`MM_ELEM_W +: `MM_ELEM_W]}};
        end
      end
      default:   w_data = {`MM_COLS{i_bus}};
    endcase
  end

  assign bank.w_data = w_data;

endmodule

`default_nettype wire

/* verilog/mem_bank_if.sv */
`timescale 1ns/100ps
`default_nettype none

`include "main_mem_defs.svh"

interface mem_bank_if;

  logic [`MM_ROW_W-1:0]   r_row;
  logic [`MM_COLS*8-1:0]  r_en;     // one bit per column byte
  logic [`MM_PARAL_W-1:0] r_data;   // masked, 2 cycles after r_row
  logic [`MM_ROW_W-1:0]   w_row;
  logic [`MM_COLS*8-1:0]  w_en;
  logic [`MM_PARAL_W-1:0] w_data;

  modport bank (
    input  r_row, r_en, w_row, w_en, w_data,
    output r_data
  );

  modport reader (
    output r_row, r_en,
    input  r_data
  );

  modport writer (
    output w_row, w_en, w_data
  );

endinterface

`default_nettype wire
